// File: riscv_pkg.sv
package riscv_pkg;

   localparam int XLEN        = 32;               // Data and address width
   localparam int REG_ADDR_W  = 5;
   localparam int NUM_REGS    = 32;
   localparam int INSTR_BYTES = 4;                // PC step per fetch

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   localparam word_t RESET_PC = '0;               // First fetch address

   // Major opcodes of the kept subset
   localparam logic [6:0] OPC_OP     = 7'b0110011; // ADD SUB AND OR XOR
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // ADDI only
   localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LW only
   localparam logic [6:0] OPC_STORE  = 7'b0100011; // SW only
   localparam logic [6:0] OPC_BRANCH = 7'b1100011; // BEQ only

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_WORD    = 3'b010;     // LW and SW
   localparam logic [2:0] F3_BEQ     = 3'b000;

   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // An all-zero value is a bubble
   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;   // Second operand is imm
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;    // Result from load data
      logic    reg_write;
      logic    branch;        // BEQ
      logic    valid;
   } ctrl_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t     ctrl;
      word_t     pc;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     rs1_data;
      word_t     rs2_data;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rd;
      word_t     alu_result;  // Also the data address
      word_t     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic      reg_write;
      reg_addr_t rd;
      word_t     result;
   } mem_wb_t;

endpackage

// File: riscv_pipe_reg.sv
`timescale 1ns/10ps

module riscv_pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset_i,
   input  logic     hold_i,           // Keep current contents
   input  logic     clear_i,          // Insert a bubble, beats hold
   input  payload_t d_i,
   output payload_t q_o
);

   always_ff @(posedge clk) begin
      if (reset_i || clear_i) begin
         q_o <= '0;
      end else if (!hold_i) begin
         q_o <= d_i;
      end
   end

   clear_gives_bubble: assert property (@(posedge clk) clear_i |=> q_o == '0)
      else $error("stage register not empty after clear");

endmodule

// File: riscv_fetch.sv
`timescale 1ns/10ps

module riscv_fetch
   import riscv_pkg::*;
(
   input  logic   clk,
   input  logic   reset_i,
   input  logic   stall_i,         // Load-use hold from decode
   input  logic   redirect_i,      // Taken branch from execute
   input  word_t  redirect_pc_i,
   input  word_t  inst_i,
   output word_t  inst_addr_o,
   output logic   inst_ce_o,
   output if_id_t if_id_o
);

   word_t pc_q;
   word_t pc_next;

   always_comb begin
      pc_next = pc_q + word_t'(INSTR_BYTES);
      if (redirect_i) begin
         pc_next = redirect_pc_i;             // Branch squashes the stalled instr
      end else if (stall_i) begin
         pc_next = pc_q;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = !reset_i && (redirect_i || !stall_i);   // Idle only while PC holds

   // Fetched word paired with its address
   assign if_id_o = '{valid: inst_ce_o, pc: pc_q, instr: inst_i};

endmodule

// File: riscv_decode.sv
`timescale 1ns/10ps

module riscv_decode
   import riscv_pkg::*;
(
   input  if_id_t    if_id_i,
   input  ctrl_t     ex_ctrl_i,       // Instruction now in ID/EX
   input  reg_addr_t ex_rd_i,
   input  word_t     rs1_data_i,
   input  word_t     rs2_data_i,
   output reg_addr_t rs1_o,
   output reg_addr_t rs2_o,
   output logic      stall_o,
   output id_ex_t    id_ex_o
);

   word_t      instr;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   ctrl_t      ctrl;
   word_t      imm;
   logic       use_rs1;
   logic       use_rs2;

   assign instr  = if_id_i.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1_o  = instr[19:15];
   assign rs2_o  = instr[24:20];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   always_comb begin
      ctrl    = '0;
      imm     = '0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      case (opcode)
         OPC_OP: begin
            ctrl.reg_write = 1'b1;
            ctrl.valid     = (funct7 == F7_BASE) ||
                             (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
            use_rs1        = 1'b1;
            use_rs2        = 1'b1;
            case (funct3)
               F3_ADD_SUB: ctrl.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_XOR:     ctrl.alu_op = ALU_XOR;
               F3_OR:      ctrl.alu_op = ALU_OR;
               F3_AND:     ctrl.alu_op = ALU_AND;
               default:    ctrl.valid  = 1'b0;   // Shifts and compares
            endcase
         end
         OPC_OP_IMM: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.valid       = (funct3 == F3_ADD_SUB);
            use_rs1          = 1'b1;
            imm              = imm_i;
         end
         OPC_LOAD: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.valid       = (funct3 == F3_WORD);
            use_rs1          = 1'b1;
            imm              = imm_i;
         end
         OPC_STORE: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
            ctrl.valid       = (funct3 == F3_WORD);
            use_rs1          = 1'b1;
            use_rs2          = 1'b1;
            imm              = imm_s;
         end
         OPC_BRANCH: begin
            ctrl.branch = 1'b1;
            ctrl.valid  = (funct3 == F3_BEQ);
            use_rs1     = 1'b1;
            use_rs2     = 1'b1;
            imm         = imm_b;
         end
         default: ctrl.valid = 1'b0;
      endcase

      if (!if_id_i.valid || !ctrl.valid) begin
         ctrl    = '0;                           // Unknown or empty slot
         use_rs1 = 1'b0;
         use_rs2 = 1'b0;
      end

      // Load result not ready until it reaches MEM/WB
      stall_o = ex_ctrl_i.valid && ex_ctrl_i.mem_read && (ex_rd_i != '0) &&
                ((use_rs1 && rs1_o == ex_rd_i) || (use_rs2 && rs2_o == ex_rd_i));

      if (stall_o) begin
         assert (if_id_i.valid)
            else $error("load-use stall raised for an empty IF/ID slot");
      end
   end

   assign id_ex_o = '{ctrl: ctrl, pc: if_id_i.pc, rs1: rs1_o, rs2: rs2_o, rd: instr[11:7],
                      rs1_data: rs1_data_i, rs2_data: rs2_data_i, imm: imm};

endmodule

// File: riscv_regfile.sv
`timescale 1ns/10ps

module riscv_regfile
   import riscv_pkg::*;
(
   input  logic      clk,
   input  logic      reset_i,
   input  reg_addr_t rs1_i,
   input  reg_addr_t rs2_i,
   output word_t     rs1_data_o,
   output word_t     rs2_data_o,
   input  mem_wb_t   wb_i              // Write port from MEM/WB
);

   word_t regs_q [NUM_REGS];
   logic  wr_en;

   assign wr_en = wb_i.reg_write && (wb_i.rd != '0);   // x0 writes dropped

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         regs_q[wb_i.rd] <= wb_i.result;
      end
   end

   function automatic word_t read_port(reg_addr_t addr);
      word_t data;
      if (addr == '0) begin
         data = '0;
      end else if (wr_en && addr == wb_i.rd) begin
         data = wb_i.result;                 // Same-cycle write-through
      end else begin
         data = regs_q[addr];
      end
      return data;
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_i);
      rs2_data_o = read_port(rs2_i);
   end

   x0_stays_zero: assert property (@(posedge clk) disable iff (reset_i) regs_q[0] == '0)
      else $error("register x0 holds a nonzero value");

endmodule

// File: riscv_execute.sv
`timescale 1ns/10ps

module riscv_execute
   import riscv_pkg::*;
(
   input  id_ex_t  id_ex_i,
   input  ex_mem_t ex_mem_fwd_i,      // One instruction older
   input  mem_wb_t mem_wb_fwd_i,      // Two instructions older
   output ex_mem_t ex_mem_o,
   output logic    redirect_o,
   output word_t   redirect_pc_o
);

   word_t op_a;
   word_t rs2_val;
   word_t op_b;
   word_t alu_res;

   // Newest producer wins
   function automatic word_t fwd(reg_addr_t rs, word_t reg_val, ex_mem_t em, mem_wb_t mw);
      word_t val;
      if (rs == '0) begin
         val = reg_val;                      // x0 is never forwarded
      end else if (em.ctrl.reg_write && !em.ctrl.mem_read && em.rd == rs) begin
         val = em.alu_result;                // Load data not there yet
      end else if (mw.reg_write && mw.rd == rs) begin
         val = mw.result;
      end else begin
         val = reg_val;
      end
      return val;
   endfunction

   always_comb begin
      op_a    = fwd(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_fwd_i, mem_wb_fwd_i);
      rs2_val = fwd(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_fwd_i, mem_wb_fwd_i);
      op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;

      case (id_ex_i.ctrl.alu_op)
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         default: alu_res = op_a + op_b;     // ADD, ADDI and address calc
      endcase

      redirect_o = id_ex_i.ctrl.valid && id_ex_i.ctrl.branch && (op_a == rs2_val);

      // A taken branch must come from decode as a pure control instruction
      if (redirect_o) begin
         assert (id_ex_i.ctrl.valid && !id_ex_i.ctrl.reg_write && !id_ex_i.ctrl.mem_write)
            else $error("redirect raised by a non-branch instruction");
      end
   end

   assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

   assign ex_mem_o = '{ctrl: id_ex_i.ctrl, rd: id_ex_i.rd, alu_result: alu_res,
                       store_data: rs2_val};

endmodule

// File: riscv.sv
`timescale 1ns/10ps

module riscv
   import riscv_pkg::*;
(
   input  logic  clk,
   input  logic  reset_i,            // Synchronous, active high

   input  word_t inst_i,             // Same-cycle instruction read
   output word_t inst_addr_o,
   output logic  inst_ce_o,

   input  word_t data_i,             // Same-cycle load data
   output word_t data_addr_o,
   output word_t data_o,
   output logic  data_ce_o,
   output logic  data_we_o
);

   if_id_t    if_id_d;
   if_id_t    if_id_q;
   id_ex_t    id_ex_d;
   id_ex_t    id_ex_q;
   ex_mem_t   ex_mem_d;
   ex_mem_t   ex_mem_q;
   mem_wb_t   mem_wb_d;
   mem_wb_t   mem_wb_q;
   logic      stall;
   logic      redirect;
   word_t     redirect_pc;
   reg_addr_t rs1;
   reg_addr_t rs2;
   word_t     rs1_data;
   word_t     rs2_data;

   riscv_fetch i_fetch (
      .clk           (clk),
      .reset_i       (reset_i),
      .stall_i       (stall),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .inst_i        (inst_i),
      .inst_addr_o   (inst_addr_o),
      .inst_ce_o     (inst_ce_o),
      .if_id_o       (if_id_d)
   );

   riscv_pipe_reg #(.payload_t(if_id_t)) i_if_id (
      .clk     (clk),
      .reset_i (reset_i),
      .hold_i  (stall),
      .clear_i (redirect),
      .d_i     (if_id_d),
      .q_o     (if_id_q)
   );

   riscv_decode i_decode (
      .if_id_i    (if_id_q),
      .ex_ctrl_i  (id_ex_q.ctrl),
      .ex_rd_i    (id_ex_q.rd),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .rs1_o      (rs1),
      .rs2_o      (rs2),
      .stall_o    (stall),
      .id_ex_o    (id_ex_d)
   );

   riscv_regfile i_regfile (
      .clk        (clk),
      .reset_i    (reset_i),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wb_i       (mem_wb_q)
   );

   riscv_pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
      .clk     (clk),
      .reset_i (reset_i),
      .hold_i  (1'b0),
      .clear_i (stall || redirect),     // Bubble on stall or squash
      .d_i     (id_ex_d),
      .q_o     (id_ex_q)
   );

   riscv_execute i_execute (
      .id_ex_i       (id_ex_q),
      .ex_mem_fwd_i  (ex_mem_q),
      .mem_wb_fwd_i  (mem_wb_q),
      .ex_mem_o      (ex_mem_d),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc)
   );

   riscv_pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
      .clk     (clk),
      .reset_i (reset_i),
      .hold_i  (1'b0),
      .clear_i (1'b0),
      .d_i     (ex_mem_d),
      .q_o     (ex_mem_q)
   );

   assign data_addr_o = ex_mem_q.alu_result;
   assign data_o      = ex_mem_q.store_data;
   assign data_ce_o   = ex_mem_q.ctrl.mem_read || ex_mem_q.ctrl.mem_write;
   assign data_we_o   = ex_mem_q.ctrl.mem_write;

   assign mem_wb_d = '{reg_write: ex_mem_q.ctrl.reg_write, rd: ex_mem_q.rd,
                       result: ex_mem_q.ctrl.mem_to_reg ? data_i : ex_mem_q.alu_result};

   riscv_pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
      .clk     (clk),
      .reset_i (reset_i),
      .hold_i  (1'b0),
      .clear_i (1'b0),
      .d_i     (mem_wb_d),
      .q_o     (mem_wb_q)
   );

endmodule

// File: tb_riscv.sv
`timescale 1ns/10ps

module tb_riscv
   import riscv_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 100;   // Per expected store
   localparam int QUIET_CYCLES   = 50;
   localparam int ROM_WORDS      = 64;
   localparam int RAM_WORDS      = 256;
   localparam int LOAD_WORD      = 16;    // Word read by the LW, byte address 0x40

   logic  clk;
   logic  reset_i;
   word_t inst_i;
   word_t inst_addr_o;
   logic  inst_ce_o;
   word_t data_i;
   word_t data_addr_o;
   word_t data_o;
   logic  data_ce_o;
   logic  data_we_o;

   word_t rom [ROM_WORDS];
   word_t ram [RAM_WORDS];
   word_t prog_q [$];                     // Program table
   word_t exp_addr_q [$];                 // Expected stores, in order
   word_t exp_data_q [$];
   word_t seen_addr_q [$];                // Stores seen on the data port
   word_t seen_data_q [$];
   int    strobe_count = 0;
   int    seed;

   riscv i_dut (
      .clk         (clk),
      .reset_i     (reset_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o)
   );

   always #5 clk = ~clk;

   // Both memories answer in the same cycle
   assign inst_i = rom[inst_addr_o[7:2]];
   assign data_i = ram[data_addr_o[9:2]];

   always @(posedge clk) begin
      if (!reset_i && data_ce_o) begin
         strobe_count++;                  // Every access, loads too
         if (data_we_o) begin
            ram[data_addr_o[9:2]] <= data_o;
            seen_addr_q.push_back(data_addr_o);
            seen_data_q.push_back(data_o);
         end
      end
   end

   function automatic word_t fill_word(int idx);
      return {16'hD00D ^ idx[15:0], idx[15:0]};
   endfunction

   function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   // SW rs2, imm(rs1)
   function automatic word_t enc_s(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t enc_b(reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, F3_BEQ, off[4:1], off[11], OPC_BRANCH};
   endfunction

   task automatic fail_stop(string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_equal(word_t actual, word_t expected, string what);
      if (actual !== expected) begin
         fail_stop($sformatf("CHECK FAILED at %0t ns: %s: got %h, expected %h",
                             $time, what, actual, expected));
      end
   endtask

   task automatic expect_store(word_t addr, word_t data);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
   endtask

   task automatic wait_for_store(int idx);
      int cycles;
      cycles = 0;
      while (seen_addr_q.size() == 0 && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (seen_addr_q.size() == 0) begin
         fail_stop($sformatf("Store %0d to address %h never appeared on the data port",
                             idx, exp_addr_q[idx]));
      end
   endtask

   task automatic build_program();
      logic [31:0] rnd;
      logic [11:0] imm_a;
      logic [11:0] imm_b;
      logic [11:0] imm_c;
      word_t       x1, x2, x3, x4, x5, x6, x7, x9;
      seed  = 71;
      rnd   = $random(seed);
      imm_a = rnd[11:0];
      rnd   = $random(seed);
      imm_b = rnd[11:0];
      rnd   = $random(seed);
      imm_c = rnd[11:0];
      x1 = {{20{imm_a[11]}}, imm_a};      // Sign-extended I immediates
      x2 = {{20{imm_b[11]}}, imm_b};
      x3 = x1 + x2;
      x4 = x3 - x1;
      x5 = x4 & x3;
      x6 = x5 | x2;
      x7 = x6 ^ x4;
      x9 = fill_word(LOAD_WORD) + x1;

      // Dependent ALU chain
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, imm_a));
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, imm_b));
      prog_q.push_back(enc_r(F7_BASE, F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
      prog_q.push_back(enc_r(F7_SUB, F3_ADD_SUB, 5'd4, 5'd3, 5'd1));
      prog_q.push_back(enc_r(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd3));
      prog_q.push_back(enc_r(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd2));
      prog_q.push_back(enc_r(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4));
      prog_q.push_back(enc_s(5'd7, 5'd0, 12'h110));   // Store data forwarded
      prog_q.push_back(enc_s(5'd3, 5'd0, 12'h100));
      prog_q.push_back(enc_s(5'd4, 5'd0, 12'h104));
      prog_q.push_back(enc_s(5'd5, 5'd0, 12'h108));
      prog_q.push_back(enc_s(5'd6, 5'd0, 12'h10C));
      // Load-use pair
      prog_q.push_back(enc_i(OPC_LOAD, F3_WORD, 5'd8, 5'd0, 12'h040));
      prog_q.push_back(enc_r(F7_BASE, F3_ADD_SUB, 5'd9, 5'd8, 5'd1));
      prog_q.push_back(enc_s(5'd9, 5'd0, 12'h114));
      // Taken branch over two marker stores, then a not-taken one
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd11, 5'd0, 12'h5A5));
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd10, 5'd0, 12'd5));
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd12, 5'd0, 12'd5));
      prog_q.push_back(enc_b(5'd10, 5'd12, 13'd12));
      prog_q.push_back(enc_s(5'd11, 5'd0, 12'h118));
      prog_q.push_back(enc_s(5'd11, 5'd0, 12'h11C));
      prog_q.push_back(enc_b(5'd10, 5'd11, 13'd8));
      prog_q.push_back(enc_s(5'd10, 5'd0, 12'h120));
      // x0 stays zero
      prog_q.push_back(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, imm_c));
      prog_q.push_back(enc_s(5'd0, 5'd0, 12'h124));
      prog_q.push_back(enc_b(5'd0, 5'd0, 13'd0));     // Self-loop

      expect_store(32'h110, x7);
      expect_store(32'h100, x3);
      expect_store(32'h104, x4);
      expect_store(32'h108, x5);
      expect_store(32'h10C, x6);
      expect_store(32'h114, x9);
      expect_store(32'h120, 32'd5);
      expect_store(32'h124, 32'd0);
   endtask

   initial begin
      int quiet_start;
      clk     = 1'b0;
      reset_i = 1'b1;
      for (int i = 0; i < RAM_WORDS; i++) begin
         ram[i] <= fill_word(i);
      end
      build_program();
      // Unused ROM holds marker stores, so a leak past the self-loop shows up
      for (int i = 0; i < ROM_WORDS; i++) begin
         rom[i] = (i < prog_q.size()) ? prog_q[i] : enc_s(5'd11, 5'd0, 12'h128);
      end

      repeat (2) @(posedge clk);
      #1 reset_i = 1'b0;

      @(negedge clk);
      check_equal(inst_addr_o, RESET_PC, "fetch address after reset");
      check_equal(word_t'(inst_ce_o), 32'd1, "inst_ce_o after reset");
      check_equal(word_t'(data_ce_o), 32'd0, "data_ce_o after reset");
      check_equal(word_t'(data_we_o), 32'd0, "data_we_o after reset");

      for (int i = 0; i < exp_addr_q.size(); i++) begin
         wait_for_store(i);
         check_equal(seen_addr_q.pop_front(), exp_addr_q[i], $sformatf("store %0d address", i));
         check_equal(seen_data_q.pop_front(), exp_data_q[i], $sformatf("store %0d data", i));
      end

      quiet_start = strobe_count;
      repeat (QUIET_CYCLES) @(negedge clk);
      check_equal(word_t'(strobe_count - quiet_start), 32'd0, "data accesses in self-loop");

      $display("all tests passed");
      $finish;
   end

endmodule

// File: tb.f
riscv_pkg.sv
riscv_pipe_reg.sv
riscv_fetch.sv
riscv_decode.sv
riscv_regfile.sv
riscv_execute.sv
riscv.sv
tb_riscv.sv

// File: Makefile
# Verilator build and run of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
